/* hdl/aluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module aluUnit
    import isaPkg::*;
(
    input  aluOpT      op,
    input  wordT       a,
    input  wordT       b,
    input  logic [4:0] shamt,
    output wordT       result,
    output logic       equal
);

    logic lessThan;

    // Signed compare for SLT
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        result = '0;
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {31'd0, lessThan};
            // Shift source is rt, carried on b
            ALU_SLL: result = b << shamt;
            ALU_LUI: result = {b[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    // Branch compare
    assign equal = (a == b);

endmodule

`default_nettype wire

/* hdl/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage
    import isaPkg::*, pipePkg::*;
(
    input  logic      CLK,
    input  logic      rstN,
    input  logic      squash,
    input  fetchPktT  fetchIn,
    input  logic      wbValid,
    input  retirePktT wb,
    output decodePktT decodeOut
);

    opcodeT      opcode;
    functT       funct;
    regIdxT      rs;
    regIdxT      rt;
    regIdxT      rd;
    logic [15:0] imm16;
    wordT        immExt;
    wordT        dataA;
    wordT        dataB;
    aluOpT       aluOp;
    regIdxT      dest;
    logic        known;
    logic        useImm;
    logic        zeroExt;
    logic        isBranch;
    logic        branchOnEq;
    decodePktT   decodeNext;

    assign opcode = fetchIn.instr[31:26];
    assign rs     = fetchIn.instr[25:21];
    assign rt     = fetchIn.instr[20:16];
    assign rd     = fetchIn.instr[15:11];
    assign funct  = fetchIn.instr[5:0];
    assign imm16  = fetchIn.instr[15:0];

    regFile regFile0 (
        .CLK      (CLK),
        .rstN     (rstN),
        .readA    (rs),
        .readB    (rt),
        .dataA    (dataA),
        .dataB    (dataB),
        .writeEn  (wbValid),
        .writeReg (wb.dest),
        .writeData(wb.result)
    );

    // --------------------
    // Opcode decode
    // --------------------
    always_comb begin
        known      = 1'b1;
        useImm     = 1'b1;
        zeroExt    = 1'b0;
        isBranch   = 1'b0;
        branchOnEq = 1'b0;
        aluOp      = ALU_ADD;
        dest       = rt;
        case (opcode)
            OP_RTYPE: begin
                useImm = 1'b0;
                dest   = rd;
                case (funct)
                    FN_ADDU: aluOp = ALU_ADD;
                    FN_SUBU: aluOp = ALU_SUB;
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_XOR:  aluOp = ALU_XOR;
                    FN_SLT:  aluOp = ALU_SLT;
                    FN_SLL:  aluOp = ALU_SLL;
                    default: known = 1'b0;
                endcase
            end
            OP_ADDIU: aluOp = ALU_ADD;
            OP_ANDI: begin
                aluOp   = ALU_AND;
                zeroExt = 1'b1;
            end
            OP_ORI: begin
                aluOp   = ALU_OR;
                zeroExt = 1'b1;
            end
            OP_LUI:  aluOp = ALU_LUI;
            OP_BEQ: begin
                isBranch   = 1'b1;
                branchOnEq = 1'b1;
            end
            OP_BNE:  isBranch = 1'b1;
            default: known = 1'b0;
        endcase
    end

    assign immExt = zeroExt ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};

    always_comb begin
        decodeNext.valid      = fetchIn.valid;
        decodeNext.opA        = dataA;
        decodeNext.opB        = useImm ? immExt : dataB;
        decodeNext.cmpB       = dataB;
        decodeNext.shamt      = fetchIn.instr[10:6];
        decodeNext.aluOp      = aluOp;
        decodeNext.dest       = dest;
        // Unknown encodings and r0 writes fall through as no-ops
        decodeNext.writeEn    = known && !isBranch && (dest != '0);
        decodeNext.isBranch   = isBranch;
        decodeNext.branchOnEq = branchOnEq;
        decodeNext.target     = fetchIn.pcPlus4 + (isBranch ? {immExt[29:0], 2'b00} : '0);
    end

    // Decode/execute register
    always_ff @(posedge CLK) begin
        decodeOut <= decodeNext;
        if (!rstN || squash) begin
            decodeOut.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hdl/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage
    import isaPkg::*, pipePkg::*;
(
    input  logic      CLK,
    input  logic      rstN,
    input  decodePktT decodeIn,
    output logic      redirect,
    output wordT      redirectPc,
    output logic      retireValid,
    output retirePktT retire
);

    wordT aluB;
    wordT aluResult;
    logic operandsEqual;
    logic taken;

    // Branches compare against the raw rt value
    assign aluB = decodeIn.isBranch ? decodeIn.cmpB : decodeIn.opB;

    aluUnit aluUnit0 (
        .op    (decodeIn.aluOp),
        .a     (decodeIn.opA),
        .b     (aluB),
        .shamt (decodeIn.shamt),
        .result(aluResult),
        .equal (operandsEqual)
    );

    // --------------------
    // Branch resolution
    // --------------------
    assign taken      = decodeIn.isBranch && (operandsEqual == decodeIn.branchOnEq);
    assign redirect   = decodeIn.valid && taken;
    assign redirectPc = decodeIn.target;

    // --------------------
    // Execute/writeback register
    // --------------------
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            retireValid <= 1'b0;
        end else begin
            retireValid <= decodeIn.valid && decodeIn.writeEn;
        end
    end

    always_ff @(posedge CLK) begin
        retire.dest   <= decodeIn.dest;
        retire.result <= aluResult;
        // Non-branches carry PC+4 in the target field
        retire.pc     <= decodeIn.target - 32'd4;
    end

endmodule

`default_nettype wire

/* hdl/fetchUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchUnit
    import isaPkg::*, pipePkg::*;
#(
    parameter wordT resetPc = '0
) (
    input  logic     CLK,
    input  logic     rstN,
    input  logic     redirect,
    input  wordT     redirectPc,
    output wordT     instrAddr,
    input  wordT     instr,
    output fetchPktT fetchOut
);

    wordT pc;
    wordT pcPlus4;

    assign pcPlus4   = pc + 32'd4;
    assign instrAddr = pc;

    // --------------------
    // Program counter
    // --------------------
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            pc <= resetPc;
        end else if (redirect) begin
            pc <= redirectPc;
        end else begin
            pc <= pcPlus4;
        end
    end

    // --------------------
    // Fetch/decode register
    // --------------------
    always_ff @(posedge CLK) begin
        fetchOut.instr   <= instr;
        fetchOut.pcPlus4 <= pcPlus4;
        // Word fetched this cycle is on the wrong path when redirected
        if (!rstN || redirect) begin
            fetchOut.valid <= 1'b0;
        end else begin
            fetchOut.valid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hdl/isaPkg.sv */
`default_nettype none

package isaPkg;

    `include "isaDefs.svh"

    typedef logic [4:0]  regIdxT;
    typedef logic [31:0] wordT;
    typedef logic [5:0]  opcodeT;
    typedef logic [5:0]  functT;

    // Operations the execute ALU knows about
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI
    } aluOpT;

    localparam opcodeT OP_RTYPE = `ISA_OP_RTYPE;
    localparam opcodeT OP_ADDIU = `ISA_OP_ADDIU;
    localparam opcodeT OP_ANDI  = `ISA_OP_ANDI;
    localparam opcodeT OP_ORI   = `ISA_OP_ORI;
    localparam opcodeT OP_LUI   = `ISA_OP_LUI;
    localparam opcodeT OP_BEQ   = `ISA_OP_BEQ;
    localparam opcodeT OP_BNE   = `ISA_OP_BNE;

    localparam functT FN_ADDU = `ISA_FN_ADDU;
    localparam functT FN_SUBU = `ISA_FN_SUBU;
    localparam functT FN_AND  = `ISA_FN_AND;
    localparam functT FN_OR   = `ISA_FN_OR;
    localparam functT FN_XOR  = `ISA_FN_XOR;
    localparam functT FN_SLT  = `ISA_FN_SLT;
    localparam functT FN_SLL  = `ISA_FN_SLL;

endpackage

`default_nettype wire

/* hdl/mipsCore.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCore
    import isaPkg::*, pipePkg::*;
#(
    parameter wordT resetPc = '0
) (
    input  logic      CLK,
    input  logic      rstN,
    output wordT      instrAddr,
    input  wordT      instr,
    output logic      retireValid,
    output retirePktT retire
);

    fetchPktT  fetchPkt;
    decodePktT decodePkt;
    logic      redirect;
    wordT      redirectPc;

    fetchUnit #(
        .resetPc(resetPc)
    ) fetch0 (
        .CLK       (CLK),
        .rstN      (rstN),
        .redirect  (redirect),
        .redirectPc(redirectPc),
        .instrAddr (instrAddr),
        .instr     (instr),
        .fetchOut  (fetchPkt)
    );

    // Retire port doubles as the register file write port
    decodeStage decode0 (
        .CLK      (CLK),
        .rstN     (rstN),
        .squash   (redirect),
        .fetchIn  (fetchPkt),
        .wbValid  (retireValid),
        .wb       (retire),
        .decodeOut(decodePkt)
    );

    executeStage execute0 (
        .CLK        (CLK),
        .rstN       (rstN),
        .decodeIn   (decodePkt),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .retireValid(retireValid),
        .retire     (retire)
    );

endmodule

`default_nettype wire

/* hdl/pipePkg.sv */
`default_nettype none

package pipePkg;

    import isaPkg::*;

    // Fetch to decode
    typedef struct packed {
        logic valid;
        wordT instr;
        wordT pcPlus4;
    } fetchPktT;

    // Decode to execute
    typedef struct packed {
        logic   valid;
        wordT   opA;
        wordT   opB;
        // Raw rt value, compared against opA by branches
        wordT   cmpB;
        logic [4:0] shamt;
        aluOpT  aluOp;
        regIdxT dest;
        logic   writeEn;
        logic   isBranch;
        logic   branchOnEq;
        // Branch target, or PC+4 when not a branch
        wordT   target;
    } decodePktT;

    // Execute to retire port and register file write
    typedef struct packed {
        regIdxT dest;
        wordT   result;
        wordT   pc;
    } retirePktT;

endpackage

`default_nettype wire

/* hdl/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile
    import isaPkg::*;
(
    input  logic   CLK,
    input  logic   rstN,
    input  regIdxT readA,
    input  regIdxT readB,
    output wordT   dataA,
    output wordT   dataB,
    input  logic   writeEn,
    input  regIdxT writeReg,
    input  wordT   writeData
);

    // Register 0 has no storage
    wordT regs [1:31];

    function automatic wordT readPort(regIdxT idx);
        if (idx == '0) begin
            return '0;
        end
        // Same-cycle write is visible to the reader
        if (writeEn && writeReg == idx) begin
            return writeData;
        end
        return regs[idx];
    endfunction

    always_comb begin
        dataA = readPort(readA);
        dataB = readPort(readB);
    end

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeReg != '0) begin
            regs[writeReg] <= writeData;
        end
    end

endmodule

`default_nettype wire

/* include/isaDefs.svh */
`ifndef ISA_DEFS_SVH
`define ISA_DEFS_SVH

// --------------------
// Primary opcodes
// --------------------
`define ISA_OP_RTYPE 6'h00
`define ISA_OP_BEQ   6'h04
`define ISA_OP_BNE   6'h05
`define ISA_OP_ADDIU 6'h09
`define ISA_OP_ANDI  6'h0c
`define ISA_OP_ORI   6'h0d
`define ISA_OP_LUI   6'h0f

// --------------------
// R-type function codes
// --------------------
`define ISA_FN_SLL   6'h00
`define ISA_FN_ADDU  6'h21
`define ISA_FN_SUBU  6'h23
`define ISA_FN_AND   6'h24
`define ISA_FN_OR    6'h25
`define ISA_FN_XOR   6'h26
`define ISA_FN_SLT   6'h2a

`endif

/* mipsCore.f */
+incdir+include
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/aluUnit.sv
hdl/regFile.sv
hdl/fetchUnit.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/mipsCore.sv
testbench/mipsCore_properties.sv
testbench/mipsCore_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -f mipsCore.f --top-module mipsCore_tb -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep "Simulation passed" > /dev/null \
    && echo "Run passed" \
    || { echo "Run failed"; exit 1; }

/* testbench/mipsCore_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCore_properties
    import isaPkg::*, pipePkg::*;
(
    input logic      CLK,
    input logic      rstN,
    input wordT      instrAddr,
    input logic      retireValid,
    input retirePktT retire
);

    wordT lastPc;
    logic haveLast;

    // PC of the previous retire since reset
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            haveLast <= 1'b0;
            lastPc   <= '0;
        end else if (retireValid) begin
            haveLast <= 1'b1;
            lastPc   <= retire.pc;
        end
    end

    // --------------------
    // Port properties
    // --------------------
    retireLowAfterReset: assert property (@(posedge CLK) !rstN |=> !retireValid)
        else $error("retireValid is high in the cycle after reset");

    noRetireToR0: assert property (@(posedge CLK) disable iff (!rstN)
        retireValid |-> (retire.dest != 5'd0))
        else $error("retire names register 0");

    fetchAligned: assert property (@(posedge CLK) disable iff (!rstN)
        instrAddr[1:0] == 2'b00)
        else $error("instrAddr is not word aligned");

    retirePcMoves: assert property (@(posedge CLK) disable iff (!rstN)
        (retireValid && haveLast) |-> (retire.pc != lastPc))
        else $error("two retires in a row carry the same PC");

endmodule

bind mipsCore mipsCore_properties props0 (
    .CLK        (CLK),
    .rstN       (rstN),
    .instrAddr  (instrAddr),
    .retireValid(retireValid),
    .retire     (retire)
);

`default_nettype wire

/* testbench/mipsCore_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCore_tb
    import isaPkg::*, pipePkg::*;
();

    localparam int   ClkPeriod   = 40;
    localparam int   ResetCycles = 3;
    localparam int   DrainCycles = 4;
    localparam int   NumTests    = 5;
    localparam wordT ResetPc     = 32'h0000_0100;
    localparam wordT Nop         = 32'h0000_0000;

    logic      CLK;
    logic      rstN;
    wordT      instrAddr;
    wordT      instr;
    logic      retireValid;
    retirePktT retire;

    wordT      imem [1024];
    wordT      allProg [$];
    int        progStart [NumTests + 1];
    retirePktT expQ [$];
    int        cyc = 0;
    int        retireErrors = 0;
    int        flowErrors = 0;
    int        testsFailed = 0;

    mipsCore #(
        .resetPc(ResetPc)
    ) dut0 (
        .CLK        (CLK),
        .rstN       (rstN),
        .instrAddr  (instrAddr),
        .instr      (instr),
        .retireValid(retireValid),
        .retire     (retire)
    );

    always #(ClkPeriod / 2) CLK = ~CLK;

    // Combinational instruction memory, zero (no-op) outside the array
    assign instr = (instrAddr < 32'd4096) ? imem[instrAddr[11:2]] : Nop;

    // Cycles since reset release
    always @(posedge CLK) begin
        if (!rstN) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    // --------------------
    // Retire checker
    // --------------------
    always @(negedge CLK) begin
        retirePktT expPkt;
        if (rstN && retireValid) begin
            assert (expQ.size() != 0) else begin
                $display("Unexpected retire of r%0d at pc %h, none was left to retire",
                         retire.dest, retire.pc);
                retireErrors++;
            end
            if (expQ.size() != 0) begin
                expPkt = expQ.pop_front();
                assert (retire == expPkt) else begin
                    $display("[FAIL] %0t: retire r%0d=%h pc %h, expected r%0d=%h pc %h",
                             $time, retire.dest, retire.result, retire.pc,
                             expPkt.dest, expPkt.result, expPkt.pc);
                    retireErrors++;
                end
                // First instruction retires three cycles after release
                if (expPkt.pc == ResetPc) begin
                    assert (cyc == 3) else begin
                        $display("[FAIL] %0t: first retire in cycle %0d, expected 3", $time, cyc);
                        retireErrors++;
                    end
                end
            end
        end
    end

    // --------------------
    // Encoders and programs
    // --------------------
    function automatic wordT iType(opcodeT op, regIdxT rs, regIdxT rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT rType(functT fn, regIdxT rs, regIdxT rt, regIdxT rd,
                                   logic [4:0] sh);
        return {OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic void emit(wordT w);
        allProg.push_back(w);
    endfunction

    function automatic void buildResetProg();
        emit(iType(OP_ADDIU, 5'd0, 5'd1, 16'h1234));
        emit(iType(OP_ORI, 5'd0, 5'd2, 16'hbeef));
        emit(Nop);
        emit(rType(FN_ADDU, 5'd1, 5'd2, 5'd3, 5'd0));
        emit(Nop);
    endfunction

    function automatic void buildAluProg();
        wordT       a;
        wordT       b;
        logic [4:0] sh;
        for (int i = 0; i < 6; i++) begin
            a  = $urandom();
            b  = $urandom();
            sh = 5'($urandom());
            // Equal operands once
            if (i == 0) begin
                b = a;
            end
            emit(iType(OP_LUI, 5'd0, 5'd1, a[31:16]));
            emit(iType(OP_LUI, 5'd0, 5'd2, b[31:16]));
            emit(iType(OP_ORI, 5'd1, 5'd1, a[15:0]));
            emit(iType(OP_ORI, 5'd2, 5'd2, b[15:0]));
            emit(Nop);
            emit(rType(FN_ADDU, 5'd1, 5'd2, 5'd3, 5'd0));
            emit(rType(FN_SUBU, 5'd1, 5'd2, 5'd4, 5'd0));
            emit(rType(FN_AND, 5'd1, 5'd2, 5'd5, 5'd0));
            emit(rType(FN_OR, 5'd1, 5'd2, 5'd6, 5'd0));
            emit(rType(FN_XOR, 5'd1, 5'd2, 5'd7, 5'd0));
            emit(rType(FN_SLT, 5'd1, 5'd2, 5'd8, 5'd0));
            emit(rType(FN_SLT, 5'd2, 5'd1, 5'd9, 5'd0));
            emit(rType(FN_SLL, 5'd0, 5'd1, 5'd10, sh));
        end
    endfunction

    function automatic void buildImmProg();
        emit(iType(OP_ADDIU, 5'd0, 5'd1, 16'hfff0));
        emit(iType(OP_ADDIU, 5'd0, 5'd2, 16'h7fff));
        emit(iType(OP_ORI, 5'd0, 5'd3, 16'h8000));
        emit(iType(OP_ANDI, 5'd1, 5'd4, 16'h8ff0));
        emit(iType(OP_ORI, 5'd1, 5'd5, 16'h000f));
        emit(iType(OP_ADDIU, 5'd1, 5'd6, 16'h8000));
        emit(iType(OP_ADDIU, 5'd2, 5'd7, 16'h0001));
        emit(Nop);
    endfunction

    function automatic void buildTakenProg();
        emit(iType(OP_ORI, 5'd0, 5'd1, 16'h0005));
        emit(iType(OP_ORI, 5'd0, 5'd2, 16'h0005));
        emit(iType(OP_ORI, 5'd0, 5'd3, 16'h0007));
        emit(Nop);
        emit(iType(OP_BEQ, 5'd1, 5'd2, 16'd3));
        emit(iType(OP_ADDIU, 5'd0, 5'd10, 16'h0001));
        emit(iType(OP_ADDIU, 5'd0, 5'd11, 16'h0002));
        emit(iType(OP_ADDIU, 5'd0, 5'd12, 16'h0003));
        emit(iType(OP_ADDIU, 5'd0, 5'd13, 16'h0004));
        emit(iType(OP_BNE, 5'd1, 5'd3, 16'd2));
        emit(iType(OP_ADDIU, 5'd0, 5'd14, 16'h0005));
        emit(iType(OP_ADDIU, 5'd0, 5'd15, 16'h0006));
        emit(iType(OP_ORI, 5'd1, 5'd16, 16'h0100));
        emit(Nop);
    endfunction

    function automatic void buildNotTakenProg();
        emit(iType(OP_ORI, 5'd0, 5'd1, 16'h0005));
        emit(iType(OP_ORI, 5'd0, 5'd2, 16'h0006));
        emit(Nop);
        emit(iType(OP_BEQ, 5'd1, 5'd2, 16'd4));
        emit(iType(OP_ADDIU, 5'd0, 5'd3, 16'h0001));
        emit(iType(OP_BNE, 5'd1, 5'd1, 16'd4));
        emit(iType(OP_ADDIU, 5'd0, 5'd4, 16'h0002));
        // Unknown opcode, unknown function code, then a write to r0
        emit(32'hfc00_0000);
        emit(rType(6'h3e, 5'd1, 5'd2, 5'd5, 5'd0));
        emit(iType(OP_ADDIU, 5'd0, 5'd0, 16'h0007));
        emit(iType(OP_ORI, 5'd2, 5'd6, 16'h0010));
        emit(Nop);
    endfunction

    task automatic loadProgram(input int t);
        logic [9:0] wordIdx;
        imem = '{default: '0};
        wordIdx = ResetPc[11:2];
        for (int i = progStart[t]; i < progStart[t + 1]; i++) begin
            imem[wordIdx] = allProg[i];
            wordIdx = wordIdx + 10'd1;
        end
    endtask

    // --------------------
    // Reference model
    // --------------------
    task automatic runModel(input int len);
        wordT      regs [32];
        wordT      pc;
        wordT      nextPc;
        wordT      endPc;
        wordT      ins;
        wordT      res;
        wordT      se;
        wordT      ze;
        regIdxT    rs;
        regIdxT    rt;
        regIdxT    dst;
        logic      wr;
        int        steps;
        retirePktT pkt;
        regs = '{default: '0};
        pc = ResetPc;
        endPc = ResetPc + wordT'(len * 4);
        steps = 0;
        expQ.delete();
        while (pc >= ResetPc && pc < endPc && steps < 4096) begin
            ins = imem[pc[11:2]];
            rs = ins[25:21];
            rt = ins[20:16];
            se = {{16{ins[15]}}, ins[15:0]};
            ze = {16'h0000, ins[15:0]};
            nextPc = pc + 32'd4;
            wr = 1'b1;
            dst = rt;
            res = '0;
            case (ins[31:26])
                OP_RTYPE: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        FN_ADDU: res = regs[rs] + regs[rt];
                        FN_SUBU: res = regs[rs] - regs[rt];
                        FN_AND:  res = regs[rs] & regs[rt];
                        FN_OR:   res = regs[rs] | regs[rt];
                        FN_XOR:  res = regs[rs] ^ regs[rt];
                        FN_SLT:  res = ($signed(regs[rs]) < $signed(regs[rt])) ? 32'd1 : 32'd0;
                        FN_SLL:  res = regs[rt] << ins[10:6];
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: res = regs[rs] + se;
                OP_ANDI:  res = regs[rs] & ze;
                OP_ORI:   res = regs[rs] | ze;
                OP_LUI:   res = {ins[15:0], 16'h0000};
                OP_BEQ: begin
                    wr = 1'b0;
                    if (regs[rs] == regs[rt]) begin
                        nextPc = pc + 32'd4 + (se << 2);
                    end
                end
                OP_BNE: begin
                    wr = 1'b0;
                    if (regs[rs] != regs[rt]) begin
                        nextPc = pc + 32'd4 + (se << 2);
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 5'd0) begin
                regs[dst] = res;
                pkt.dest = dst;
                pkt.result = res;
                pkt.pc = pc;
                expQ.push_back(pkt);
            end
            pc = nextPc;
            steps++;
        end
    endtask

    // --------------------
    // Test sequencing
    // --------------------
    task automatic runTest(input int t, input string name);
        int len;
        int waited;
        int errBefore;
        errBefore = retireErrors + flowErrors;
        len = progStart[t + 1] - progStart[t];
        @(posedge CLK);
        #1 rstN = 1'b0;
        loadProgram(t);
        runModel(len);
        repeat (ResetCycles) @(posedge CLK);
        #1 rstN = 1'b1;
        @(negedge CLK);
        assert (instrAddr == ResetPc) else begin
            $display("[FAIL] %0t: first fetch at %h, expected %h", $time, instrAddr, ResetPc);
            flowErrors++;
        end
        waited = 0;
        while (expQ.size() != 0 && waited < 2 * len + 8) begin
            @(posedge CLK);
            waited++;
        end
        assert (expQ.size() == 0) else begin
            $display("Test %s timed out with %0d expected retires still missing",
                     name, expQ.size());
            flowErrors++;
        end
        // Any stray retire would show up while the pipeline drains
        repeat (DrainCycles) @(posedge CLK);
        if (retireErrors + flowErrors == errBefore) begin
            $display("Test %0d %-16s ok", t, name);
        end else begin
            $display("Test %0d %-16s FAILED", t, name);
            testsFailed++;
        end
    endtask

    initial begin
        int totalLen;
        int limitCycles;
        CLK = 1'b0;
        rstN = 1'b0;
        imem = '{default: '0};
        void'($urandom(32'h5419));
        progStart[0] = 0;
        buildResetProg();
        progStart[1] = allProg.size();
        buildAluProg();
        progStart[2] = allProg.size();
        buildImmProg();
        progStart[3] = allProg.size();
        buildTakenProg();
        progStart[4] = allProg.size();
        buildNotTakenProg();
        progStart[5] = allProg.size();
        // Twice the program lengths, plus reset and drain per test
        totalLen = allProg.size();
        limitCycles = 2 * totalLen + 24 * NumTests;
        fork
            begin
                #(limitCycles * ClkPeriod);
                $display("Watchdog expired after %0d cycles, the run did not finish",
                         limitCycles);
                $display("Simulation failed");
                $finish;
            end
        join_none
        runTest(0, "reset state");
        runTest(1, "alu results");
        runTest(2, "immediates");
        runTest(3, "taken branches");
        runTest(4, "not taken/no-op");
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors", NumTests,
                 NumTests - testsFailed, testsFailed, retireErrors + flowErrors);
        if (testsFailed == 0 && retireErrors + flowErrors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
